// File: l2_dir_pkg.sv
// L2 directory package with cache geometry, vector types, the operation encoding and pipeline structs
package l2_dir_pkg;

	// Cache geometry
	localparam int l2_num_ways = 4;
	localparam int l2_set_index_width = 4;
	localparam int l2_num_sets = 16;
	localparam int addr_width = 26;
	localparam int l2_tag_width = addr_width - l2_set_index_width;
	localparam int l1_set_index_width = 3;
	localparam int l1_tag_width = 23;

	// Directory is indexed by {l2 way, l2 set}
	localparam int dir_index_width = 6;

	typedef logic [addr_width - 1:0] l2_addr_t;
	typedef logic [l2_set_index_width - 1:0] l2_set_t;
	typedef logic [l2_tag_width - 1:0] l2_tag_t;
	typedef logic [l1_tag_width - 1:0] l1_tag_t;
	typedef logic [1:0] way_t;
	typedef logic [1:0] unit_t;
	typedef logic [1:0] strand_t;
	typedef logic [l2_num_ways - 1:0] way_mask_t;

	// Flush passes down the pipeline but leaves the directory alone
	typedef enum logic [2:0] {
		op_load       = 3'd0,
		op_store      = 3'd1,
		op_flush      = 3'd2,
		op_load_sync  = 3'd3,
		op_store_sync = 3'd4
	} pci_op_t;

	typedef struct packed {
		logic     valid;
		unit_t    unit;
		strand_t  strand;
		pci_op_t  op;
		way_t     l1_way;
		l2_addr_t address;
		logic     has_fill;
		way_t     fill_way;
	} l2_req_t;

	typedef struct packed {
		l2_tag_t tag;
		logic    valid;
	} way_lookup_t;

	typedef struct packed {
		l2_req_t   req;
		logic      cache_hit;
		way_t      hit_way;
		way_t      replace_way;
		l2_tag_t   replace_tag;
		way_mask_t dirty;
		logic      l1_valid;
		way_t      l1_way;
		l1_tag_t   l1_tag;
	} dir_result_t;

endpackage

// File: l2_tag_way.sv
// L2 tag way bank holding tag and valid bits per set with a registered lookup and fill write
`timescale 1ns/100ps

module l2_tag_way (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     stall,
	input  l2_dir_pkg::way_t         way_id,
	input  l2_dir_pkg::l2_set_t      lookup_set,
	input  logic                     fill_en,
	input  l2_dir_pkg::way_t         fill_way,
	input  l2_dir_pkg::l2_set_t      fill_set,
	input  l2_dir_pkg::l2_tag_t      fill_tag,
	output l2_dir_pkg::way_lookup_t  lookup
);

	import l2_dir_pkg::*;

	l2_tag_t tag_mem [0:l2_num_sets - 1];
	logic [l2_num_sets - 1:0] valid_bits;
	logic fill_hit;

	// The fill strobe is broadcast to all banks, only the addressed way takes it
	assign fill_hit = fill_en && (fill_way == way_id);

	// Fill writes the tag of the addressed set
	always_ff @(posedge clk)
	begin
		if (fill_hit)
			tag_mem[fill_set] <= fill_tag;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_bits <= '0;
		end
		else if (fill_hit)
		begin
			valid_bits[fill_set] <= 1'b1;
		end
	end

	// Lookup samples the arrays before this edge's fill lands, so a fill and a
	// lookup to the same set in one cycle returns the previous contents
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lookup <= '0;
		end
		else if (!stall)
		begin
			lookup.tag <= tag_mem[lookup_set];
			lookup.valid <= valid_bits[lookup_set];
		end
	end

	// A fill must never arrive while the pipeline is frozen
	a_fill_not_stalled: assert property (
		@(posedge clk) disable iff (!rst_n)
		fill_hit |-> !stall
	) else $error("l2_tag_way: fill strobe during stall");

endmodule

// File: l2_tag_stage.sv
// L2 tag stage registering the request, driving the way banks and keeping round-robin pointers
`timescale 1ns/100ps

module l2_tag_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall,
	input  l2_dir_pkg::l2_req_t  req,
	output l2_dir_pkg::l2_req_t  tag_req,
	output l2_dir_pkg::l2_set_t  lookup_set,
	output logic                 fill_en,
	output l2_dir_pkg::l2_set_t  fill_set,
	output l2_dir_pkg::l2_tag_t  fill_tag,
	output l2_dir_pkg::way_t     fill_way,
	output l2_dir_pkg::way_t     replace_way
);

	import l2_dir_pkg::*;

	l2_set_t req_set;
	l2_tag_t req_tag;
	way_t rr_ptr [0:l2_num_sets - 1];

	assign req_set = req.address[l2_set_index_width - 1:0];
	assign req_tag = req.address[addr_width - 1:l2_set_index_width];

	// The banks read the incoming set on the same edge that samples the request
	assign lookup_set = req_set;

	// The fill port is qualified with stall so the banks see a clean strobe
	assign fill_en = req.valid && req.has_fill && !stall;
	assign fill_set = req_set;
	assign fill_tag = req_tag;
	assign fill_way = req.fill_way;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tag_req <= '0;
		end
		else if (!stall)
		begin
			tag_req <= req;
		end
	end

	// Victim pointer for the requested set travels alongside the request
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			replace_way <= '0;
		end
		else if (!stall)
		begin
			replace_way <= rr_ptr[req_set];
		end
	end

	// Each fill into a set moves that set's pointer on by one way,
	// independent of which way the fill actually went to
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < l2_num_sets; s++)
				rr_ptr[s] <= '0;
		end
		else if (fill_en)
		begin
			rr_ptr[req_set] <= rr_ptr[req_set] + way_t'(1);
		end
	end

	// Flush requests come from the core side and never carry fill data
	a_flush_no_fill: assert property (
		@(posedge clk) disable iff (!rst_n)
		(req.valid && req.op == op_flush) |-> !req.has_fill
	) else $error("l2_tag_stage: flush request carries a fill");

endmodule

// File: l2_cache_dir.sv
// L2 directory stage resolving hit and victim, tracking dirty bits and the L1 inclusion directory
`timescale 1ns/100ps

module l2_cache_dir (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     stall,
	input  l2_dir_pkg::l2_req_t      tag_req,
	input  l2_dir_pkg::way_t         replace_way,
	input  l2_dir_pkg::way_lookup_t  ways [0:l2_dir_pkg::l2_num_ways - 1],
	output l2_dir_pkg::dir_result_t  result
);

	import l2_dir_pkg::*;

	l2_set_t req_set;
	l2_tag_t req_tag;
	l1_tag_t req_l1_tag;
	way_mask_t hit_mask;
	way_t hit_way;
	logic cache_hit;
	l2_tag_t replace_tag;
	logic is_load;
	logic is_store;
	way_t sel_way;
	logic [dir_index_width - 1:0] dir_index;
	logic dir_wr;

	// One dirty mask per set
	way_mask_t dirty_mem [0:l2_num_sets - 1];

	// Inclusion directory for the single L1 is keyed by {l2 way, l2 set}
	logic [l2_num_ways * l2_num_sets - 1:0] dir_valid_mem;
	way_t dir_way_mem [0:l2_num_ways * l2_num_sets - 1];
	l1_tag_t dir_tag_mem [0:l2_num_ways * l2_num_sets - 1];

	assign req_set = tag_req.address[l2_set_index_width - 1:0];
	assign req_tag = tag_req.address[addr_width - 1:l2_set_index_width];
	assign req_l1_tag = tag_req.address[addr_width - 1:l1_set_index_width];

	always_comb
	begin
		hit_mask = '0;
		hit_way = '0;
		for (int i = 0; i < l2_num_ways; i++)
			hit_mask[i] = ways[i].valid && (ways[i].tag == req_tag);

		// Only one way may match, so the scan order is irrelevant in practice
		for (int i = l2_num_ways - 1; i >= 0; i--)
		begin
			if (hit_mask[i])
				hit_way = way_t'(i);
		end
	end

	assign cache_hit = |hit_mask;
	assign replace_tag = ways[replace_way].tag;

	assign is_load = (tag_req.op == op_load) || (tag_req.op == op_load_sync);
	assign is_store = (tag_req.op == op_store) || (tag_req.op == op_store_sync);

	// A fill targets its own way; a miss without fill looks at the victim's entry
	assign sel_way = tag_req.has_fill ? tag_req.fill_way :
		(cache_hit ? hit_way : replace_way);
	assign dir_index = {sel_way, req_set};
	assign dir_wr = tag_req.valid && is_load && (cache_hit || tag_req.has_fill);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < l2_num_sets; s++)
				dirty_mem[s] <= '0;
		end
		else if (!stall && tag_req.valid)
		begin
			// A store marks the line it writes and a plain fill brings in clean data
			if (is_store && (cache_hit || tag_req.has_fill))
				dirty_mem[req_set][sel_way] <= 1'b1;
			else if (tag_req.has_fill)
				dirty_mem[req_set][sel_way] <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dir_valid_mem <= '0;
		end
		else if (!stall && dir_wr)
		begin
			dir_valid_mem[dir_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall && dir_wr)
		begin
			dir_way_mem[dir_index] <= tag_req.l1_way;
			dir_tag_mem[dir_index] <= req_l1_tag;
		end
	end

	// Directory and dirty reads see the values from before this edge's update
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			result <= '0;
		end
		else if (!stall)
		begin
			result.req <= tag_req;
			result.cache_hit <= cache_hit;
			result.hit_way <= hit_way;
			result.replace_way <= replace_way;
			result.replace_tag <= replace_tag;
			result.dirty <= dirty_mem[req_set];
			result.l1_valid <= dir_valid_mem[dir_index];
			result.l1_way <= dir_way_mem[dir_index];
			result.l1_tag <= dir_tag_mem[dir_index];
		end
	end

	// Tag banks must never hold the same line in two ways
	a_one_hit: assert property (
		@(posedge clk) disable iff (!rst_n)
		tag_req.valid |-> $onehot0(hit_mask)
	) else $error("l2_cache_dir: more than one way hit");

	// Fill requests are only issued for lines that missed
	a_fill_misses: assert property (
		@(posedge clk) disable iff (!rst_n)
		(tag_req.valid && tag_req.has_fill) |-> !cache_hit
	) else $error("l2_cache_dir: fill request hit in the cache");

endmodule

// File: l2_dir_top.sv
// L2 lookup pipeline top joining the tag stage, four tag way banks and the directory stage
`timescale 1ns/100ps

module l2_dir_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     stall,
	input  l2_dir_pkg::l2_req_t      req,
	output l2_dir_pkg::dir_result_t  result
);

	import l2_dir_pkg::*;

	l2_req_t tag_req;
	l2_set_t lookup_set;
	logic fill_en;
	l2_set_t fill_set;
	l2_tag_t fill_tag;
	way_t fill_way;
	way_t replace_way;
	way_lookup_t ways [0:l2_num_ways - 1];

	l2_tag_stage u_tag_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (stall),
		.req         (req),
		.tag_req     (tag_req),
		.lookup_set  (lookup_set),
		.fill_en     (fill_en),
		.fill_set    (fill_set),
		.fill_tag    (fill_tag),
		.fill_way    (fill_way),
		.replace_way (replace_way)
	);

	// One bank per way, each told its own way number
	for (genvar w = 0; w < l2_num_ways; w++)
	begin : g_way
		l2_tag_way u_tag_way (
			.clk        (clk),
			.rst_n      (rst_n),
			.stall      (stall),
			.way_id     (way_t'(w)),
			.lookup_set (lookup_set),
			.fill_en    (fill_en),
			.fill_way   (fill_way),
			.fill_set   (fill_set),
			.fill_tag   (fill_tag),
			.lookup     (ways[w])
		);
	end

	l2_cache_dir u_cache_dir (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (stall),
		.tag_req     (tag_req),
		.replace_way (replace_way),
		.ways        (ways),
		.result      (result)
	);

endmodule

// File: l2_dir_tb.sv
// Directed testbench for the L2 lookup pipeline against a model of tags, dirty bits and directory
`timescale 1ns/100ps

module l2_dir_tb;

	import l2_dir_pkg::*;

	// Longest run is well under a few hundred cycles including reset
	localparam int max_cycles = 2000;

	typedef struct packed {
		dir_result_t exp;
		logic        chk_rtag;
		int          due;
	} exp_entry_t;

	logic clk;
	logic rst_n;
	logic stall;
	l2_req_t req;
	dir_result_t result;

	int errors;
	int checks;
	int cycle_count;
	int adv_count;
	logic stall_seen;
	exp_entry_t exp_q [$];

	// Reference model arrays are indexed [way][set]
	l2_tag_t m_tag [0:l2_num_ways - 1][0:l2_num_sets - 1];
	logic m_valid [0:l2_num_ways - 1][0:l2_num_sets - 1];
	way_mask_t m_dirty [0:l2_num_sets - 1];
	way_t m_ptr [0:l2_num_sets - 1];
	logic d_valid [0:l2_num_ways - 1][0:l2_num_sets - 1];
	way_t d_way [0:l2_num_ways - 1][0:l2_num_sets - 1];
	l1_tag_t d_tag [0:l2_num_ways - 1][0:l2_num_sets - 1];

	l2_dir_top uut (
		.clk    (clk),
		.rst_n  (rst_n),
		.stall  (stall),
		.req    (req),
		.result (result)
	);

	always #5 clk = ~clk;

	// Only unstalled edges move the pipeline, so latency is counted in those
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		stall_seen <= stall;
		if (rst_n && !stall)
			adv_count <= adv_count + 1;
	end

	task automatic expect_equal(input string what, input logic [63:0] got,
		input logic [63:0] want);
		checks++;
		assert (got === want)
		else
		begin
			errors++;
			$display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	// A fresh result is registered only on an edge where stall was low
	always @(negedge clk)
	begin
		exp_entry_t e;
		if (rst_n && !stall_seen && result.req.valid)
		begin
			checks++;
			assert (exp_q.size() != 0)
			else
			begin
				errors++;
				$display("A result came out at %0t with no request outstanding", $time);
			end
			if (exp_q.size() != 0)
			begin
				e = exp_q.pop_front();
				expect_equal("request", 64'(result.req), 64'(e.exp.req));
				expect_equal("latency", 64'(adv_count), 64'(e.due));
				expect_equal("cache_hit", 64'(result.cache_hit), 64'(e.exp.cache_hit));
				if (e.exp.cache_hit)
					expect_equal("hit_way", 64'(result.hit_way), 64'(e.exp.hit_way));
				expect_equal("replace_way", 64'(result.replace_way), 64'(e.exp.replace_way));
				if (e.chk_rtag)
					expect_equal("replace_tag", 64'(result.replace_tag), 64'(e.exp.replace_tag));
				expect_equal("dirty", 64'(result.dirty), 64'(e.exp.dirty));
				expect_equal("l1_valid", 64'(result.l1_valid), 64'(e.exp.l1_valid));
				if (e.exp.l1_valid)
				begin
					expect_equal("l1_way", 64'(result.l1_way), 64'(e.exp.l1_way));
					expect_equal("l1_tag", 64'(result.l1_tag), 64'(e.exp.l1_tag));
				end
			end
		end
	end

	task automatic clear_model();
		for (int s = 0; s < l2_num_sets; s++)
		begin
			m_dirty[s] = '0;
			m_ptr[s] = '0;
			for (int w = 0; w < l2_num_ways; w++)
			begin
				m_tag[w][s] = '0;
				m_valid[w][s] = 1'b0;
				d_valid[w][s] = 1'b0;
				d_way[w][s] = '0;
				d_tag[w][s] = '0;
			end
		end
	endtask

	// Random tag that is not yet held anywhere in the set, so fills always miss
	function automatic l2_tag_t fresh_tag(input l2_set_t s);
		l2_tag_t t;
		logic taken;
		do
		begin
			t = l2_tag_t'($urandom);
			taken = 1'b0;
			for (int w = 0; w < l2_num_ways; w++)
				if (m_valid[w][s] && m_tag[w][s] == t)
					taken = 1'b1;
		end
		while (taken);
		return t;
	endfunction

	function automatic l2_req_t make_req(input pci_op_t op, input l2_tag_t t, input l2_set_t s,
		input way_t l1w, input logic fill, input way_t fw);
		l2_req_t r;
		r = '0;
		r.valid = 1'b1;
		r.unit = unit_t'($urandom);
		r.strand = strand_t'($urandom);
		r.op = op;
		r.l1_way = l1w;
		r.address = {t, s};
		r.has_fill = fill;
		r.fill_way = fw;
		return r;
	endfunction

	// Reads use the state before this request, then the request's own updates are applied
	task automatic predict(input l2_req_t r);
		exp_entry_t e;
		l2_set_t s;
		l2_tag_t t;
		way_t sw;
		logic hit;
		s = r.address[l2_set_index_width - 1:0];
		t = r.address[addr_width - 1:l2_set_index_width];
		e = '0;
		for (int w = 0; w < l2_num_ways; w++)
		begin
			if (m_valid[w][s] && m_tag[w][s] == t)
			begin
				e.exp.cache_hit = 1'b1;
				e.exp.hit_way = way_t'(w);
			end
		end
		hit = e.exp.cache_hit;
		sw = r.has_fill ? r.fill_way : (hit ? e.exp.hit_way : m_ptr[s]);
		e.exp.req = r;
		e.exp.replace_way = m_ptr[s];
		e.exp.replace_tag = m_tag[m_ptr[s]][s];
		e.exp.dirty = m_dirty[s];
		e.exp.l1_valid = d_valid[sw][s];
		e.exp.l1_way = d_way[sw][s];
		e.exp.l1_tag = d_tag[sw][s];
		e.chk_rtag = m_valid[m_ptr[s]][s];
		e.due = adv_count + 2;
		exp_q.push_back(e);
		if (r.op inside {op_store, op_store_sync} && (hit || r.has_fill))
			m_dirty[s][sw] = 1'b1;
		else if (r.has_fill)
			m_dirty[s][sw] = 1'b0;
		if (r.op inside {op_load, op_load_sync} && (hit || r.has_fill))
		begin
			d_valid[sw][s] = 1'b1;
			d_way[sw][s] = r.l1_way;
			d_tag[sw][s] = r.address[addr_width - 1:l1_set_index_width];
		end
		if (r.has_fill)
		begin
			m_tag[r.fill_way][s] = t;
			m_valid[r.fill_way][s] = 1'b1;
			m_ptr[s] = m_ptr[s] + 2'd1;
		end
	endtask

	task automatic send(input l2_req_t r);
		predict(r);
		req = r;
		@(posedge clk);
		#1;
		req = '0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic test_reset_misses();
		for (int s = 0; s < l2_num_sets; s++)
			send(make_req(op_load, fresh_tag(l2_set_t'(s)), l2_set_t'(s), way_t'(s), 1'b0, '0));
		drain();
	endtask

	task automatic test_fill_hit();
		l2_tag_t t;
		t = fresh_tag(4'd5);
		send(make_req(op_load, t, 4'd5, 2'd2, 1'b1, m_ptr[5]));
		send(make_req(op_load, t, 4'd5, 2'd1, 1'b0, '0));
		send(make_req(op_load_sync, t, 4'd5, 2'd3, 1'b0, '0));
		drain();
	endtask

	task automatic test_dirty();
		l2_tag_t first;
		l2_tag_t t;
		first = fresh_tag(4'd9);
		send(make_req(op_load, first, 4'd9, 2'd0, 1'b1, m_ptr[9]));
		// Filling the other three ways wraps the pointer back onto the first line
		for (int i = 1; i < l2_num_ways; i++)
			send(make_req(op_load, fresh_tag(4'd9), 4'd9, way_t'(i), 1'b1, m_ptr[9]));
		send(make_req(op_store, first, 4'd9, 2'd0, 1'b0, '0));
		send(make_req(op_load, first, 4'd9, 2'd0, 1'b0, '0));
		t = fresh_tag(4'd9);
		send(make_req(op_load, t, 4'd9, 2'd1, 1'b1, m_ptr[9]));
		send(make_req(op_load, t, 4'd9, 2'd1, 1'b0, '0));
		drain();
	endtask

	task automatic test_round_robin();
		for (int i = 0; i < 5; i++)
			send(make_req(op_store_sync, fresh_tag(4'd12), 4'd12, 2'd0, 1'b1, m_ptr[12]));
		drain();
	endtask

	task automatic test_stall();
		l2_tag_t t;
		l2_req_t held_req;
		dir_result_t held;
		t = fresh_tag(4'd3);
		send(make_req(op_load, t, 4'd3, 2'd1, 1'b1, m_ptr[3]));
		send(make_req(op_load, t, 4'd3, 2'd2, 1'b0, '0));
		// This request waits at the input for the whole stall
		held_req = make_req(op_store, fresh_tag(4'd3), 4'd3, 2'd3, 1'b1, m_ptr[3]);
		predict(held_req);
		req = held_req;
		stall = 1'b1;
		held = result;
		repeat (6)
		begin
			@(posedge clk);
			#1;
			checks++;
			assert (result === held)
			else
			begin
				errors++;
				$display("FAIL %0t: result changed while stalled", $time);
			end
		end
		stall = 1'b0;
		@(posedge clk);
		#1;
		req = '0;
		send(make_req(op_load, t, 4'd3, 2'd0, 1'b0, '0));
		drain();
	endtask

	task automatic test_back_to_back();
		l2_tag_t t;
		send(make_req(op_store, fresh_tag(4'd14), 4'd14, 2'd0, 1'b1, 2'd2));
		drain();
		t = fresh_tag(4'd14);
		send(make_req(op_load, t, 4'd14, 2'd3, 1'b1, 2'd2));
		send(make_req(op_load, t, 4'd14, 2'd1, 1'b0, '0));
		send(make_req(op_store, t, 4'd14, 2'd0, 1'b0, '0));
		send(make_req(op_load_sync, t, 4'd14, 2'd2, 1'b0, '0));
		drain();
	endtask

	initial
	begin
		wait (cycle_count >= max_cycles);
		$display("Run stopped by timeout after %0d cycles, %0d results outstanding",
			cycle_count, exp_q.size());
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		rst_n = 1'b0;
		stall = 1'b0;
		req = '0;
		clk = 1'b0;
		void'($urandom(32'h15e6));
		clear_model();
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset_misses();
		test_fill_hit();
		test_dirty();
		test_round_robin();
		test_stall();
		test_back_to_back();
		repeat (4) @(posedge clk);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: l2_dir.f
l2_dir_pkg.sv
l2_tag_way.sv
l2_tag_stage.sv
l2_cache_dir.sv
l2_dir_top.sv
l2_dir_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = l2_dir_tb
FILELIST = l2_dir.f

OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
